//--- sim.f
+incdir+include
logic/memTypesPkg.sv
logic/scanPkg.sv
logic/syncRam4kx9_1rw1r.sv
logic/hostPort.sv
logic/scanAddressCounter.sv
logic/scanSequencer.sv
logic/scanChecker.sv
logic/memScrubTop.sv
sim/memScrub_sva.sv
sim/memScrubTb.sv

//--- run.sh
#!/bin/sh
# builds memScrubTb with Verilator, runs it and judges the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module memScrubTb -f sim.f -o memScrubSim \
	|| { echo "verilator build failed"; exit 1; }
./obj_dir/memScrubSim 2>&1 | tee sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

//--- sim/memScrubTb.sv
`include "scrub_params.svh"

module memScrubTb import memTypesPkg::*, scanPkg::*; ();

	localparam int memDepth = 1 << `ADDR_WIDTH;
	localparam int hostOps = 200 + 200 + 300 + 256 + 20 + memDepth + 2; // host writes and reads
	localparam int scanWords = 300 + 256 + 12 + memDepth + 3 * 40; // scans plus the idle wait
	localparam int cycleLimit = hostOps + scanWords + 20000; // margin covers per-op overhead

	logic wclk;
	logic reset;
	logic hostEn;
	logic hostWe;
	logic hostCorrupt;
	addr_t hostAddr;
	byte_t hostWrData;
	byte_t hostRdData;
	logic hostRdParityErr;
	logic scanStart;
	addr_t startAddr;
	scanLen_t scanLength;
	logic busy;
	logic done;
	errCount_t errCount;
	addr_t firstErrAddr;
	logic firstErrValid;
	csum_t checksum;

	byte_t modelData [memDepth]; // bytes as the host last wrote them
	bit modelBad [memDepth]; // word was stored with inverted parity

	int cycleCount = 0; // rising edges seen so far
	int stimErrors = 0; // failures found by the stimulus process
	int compareErrors = 0; // failures found by the compare process
	int errorsAtTestStart = 0;
	int testNum = 0;
	int testsFailed = 0;
	int scansStarted = 0; // scans the stimulus expects a done for
	int doneCount = 0; // done pulses seen
	bit afterDone = 1'b0; // done was up at the previous falling edge
	int expDoneCycle; // cycle count at which done must be up
	errCount_t expErrCount;
	addr_t expFirstAddr;
	logic expFirstValid;
	csum_t expCsum;
	int rdDue [$]; // cycle at which each host read returns
	byte_t rdExpData [$];
	bit rdExpErr [$];
	int rdChecked = 0; // reads compared so far, the queues are never popped

	memScrubTop memScrubTop_i (
		.wclk(wclk), .reset(reset),
		.hostEn(hostEn), .hostWe(hostWe), .hostCorrupt(hostCorrupt),
		.hostAddr(hostAddr), .hostWrData(hostWrData),
		.hostRdData(hostRdData), .hostRdParityErr(hostRdParityErr),
		.scanStart(scanStart), .startAddr(startAddr), .scanLength(scanLength),
		.busy(busy), .done(done),
		.errCount(errCount), .firstErrAddr(firstErrAddr),
		.firstErrValid(firstErrValid), .checksum(checksum)
	);

	bind scanSequencer memScrubChecks memScrubChecks_i (
		.wclk(wclk), .reset(reset), .state(state),
		.scanRead(scanRead), .busy(busy), .done(done)
	);

	always #20 wclk = ~wclk; // 40 unit period

	always @(posedge wclk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic int noteWrongValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("mismatch at time %0t: %s expected %0d got %0d", $time, name, expected, actual);
		return 1;
	endfunction

	// sum, bad count and first bad word of a range taken in scan order, wrapping at the top
	function automatic void modelScan(input int start, input int len, output errCount_t errs,
			output addr_t firstAddr, output logic firstValid, output csum_t csum);
		int a;
		errs = '0;
		firstAddr = '0;
		firstValid = 1'b0;
		csum = '0;
		for (int k = 0; k < len; k++) begin
			a = (start + k) % memDepth;
			csum = csum + csum_t'(modelData[a]); // bad words still add their byte
			if (modelBad[a]) begin
				if (!firstValid) begin
					firstAddr = addr_t'(a);
					firstValid = 1'b1;
				end
				errs = errs + errCount_t'(1);
			end
		end
	endfunction

	// outputs are sampled on the falling edge, half a cycle after they change
	always @(negedge wclk) begin
		if (afterDone && busy !== 1'b0)
			compareErrors += noteWrongValue("busy", 0, 32'(busy)); // idle after done
		afterDone = !reset && done;
		if (!reset && done) begin
			doneCount = doneCount + 1;
			if (doneCount > scansStarted) begin
				$display("error at time %0t: done pulsed with no scan started", $time);
				compareErrors = compareErrors + 1;
			end else begin
				if (cycleCount != expDoneCycle)
					compareErrors += noteWrongValue("done cycle", expDoneCycle, cycleCount);
				if (busy !== 1'b0)
					compareErrors += noteWrongValue("busy", 0, 32'(busy));
				if (errCount !== expErrCount)
					compareErrors += noteWrongValue("errCount", 32'(expErrCount), 32'(errCount));
				if (firstErrValid !== expFirstValid)
					compareErrors += noteWrongValue("firstErrValid", 32'(expFirstValid),
						32'(firstErrValid));
				if (expFirstValid && firstErrAddr !== expFirstAddr)
					compareErrors += noteWrongValue("firstErrAddr", 32'(expFirstAddr),
						32'(firstErrAddr));
				if (checksum !== expCsum)
					compareErrors += noteWrongValue("checksum", 32'(expCsum), 32'(checksum));
			end
		end
		if (rdChecked < rdDue.size() && rdDue[rdChecked] == cycleCount) begin
			if (hostRdData !== rdExpData[rdChecked])
				compareErrors += noteWrongValue("hostRdData", 32'(rdExpData[rdChecked]),
					32'(hostRdData));
			if (hostRdParityErr !== rdExpErr[rdChecked])
				compareErrors += noteWrongValue("hostRdParityErr", 32'(rdExpErr[rdChecked]),
					32'(hostRdParityErr));
			rdChecked = rdChecked + 1;
		end
	end

	task automatic writeByte(input int addr, input byte_t data, input bit corrupt);
		@(negedge wclk);
		hostEn = 1'b1; // stays up, so back to back calls write one word per cycle
		hostWe = 1'b1;
		hostCorrupt = corrupt;
		hostAddr = addr_t'(addr);
		hostWrData = data;
		modelData[addr] = data;
		modelBad[addr] = corrupt;
	endtask

	task automatic readAndExpect(input int addr);
		@(negedge wclk);
		hostEn = 1'b1;
		hostWe = 1'b0;
		hostCorrupt = 1'b0;
		hostAddr = addr_t'(addr);
		rdDue.push_back(cycleCount + 3); // sampled at the next edge, data two edges later
		rdExpData.push_back(modelData[addr]);
		rdExpErr.push_back(modelBad[addr]);
	endtask

	task automatic hostIdle();
		@(negedge wclk);
		hostEn = 1'b0;
		hostWe = 1'b0;
		hostCorrupt = 1'b0;
		while (rdChecked < rdDue.size()) begin
			@(posedge wclk); // let the outstanding reads come back
		end
	endtask

	task automatic runScan(input int start, input int len, input bit secondStart);
		int donesBefore;
		modelScan(start, len, expErrCount, expFirstAddr, expFirstValid, expCsum);
		donesBefore = doneCount;
		@(negedge wclk);
		hostEn = 1'b0;
		startAddr = addr_t'(start);
		scanLength = scanLen_t'(len);
		scanStart = 1'b1;
		expDoneCycle = cycleCount + len + 3; // sampled at the next edge, then length+2 more
		scansStarted = scansStarted + 1;
		@(negedge wclk);
		scanStart = 1'b0;
		if (secondStart) begin
			repeat (4) @(negedge wclk);
			if (busy !== 1'b1)
				stimErrors += noteWrongValue("busy", 1, 32'(busy));
			startAddr = startAddr + addr_t'(100); // a different range, which must not run
			scanLength = scanLen_t'(5);
			scanStart = 1'b1;
			@(negedge wclk);
			scanStart = 1'b0;
		end
		while (doneCount == donesBefore) begin
			@(posedge wclk);
		end
		if (secondStart) begin
			repeat (len + 10) @(posedge wclk); // a second scan would have finished by now
			if (doneCount != donesBefore + 1) begin
				$display("error at time %0t: start while busy produced another done", $time);
				stimErrors = stimErrors + 1;
			end
		end
	endtask

	task automatic closeTest(input string name);
		int total;
		total = stimErrors + compareErrors;
		testNum = testNum + 1;
		$display("test %0d %s: %0d errors", testNum, name, total - errorsAtTestStart);
		if (total != errorsAtTestStart)
			testsFailed = testsFailed + 1;
		errorsAtTestStart = total;
	endtask

	initial begin
		int addrList [$];
		int start;
		int a;
		void'($urandom(32'h72c0_f9da));
		wclk = 1'b0;
		reset = 1'b1;
		hostEn = 1'b0;
		hostWe = 1'b0;
		hostCorrupt = 1'b0;
		hostAddr = '0;
		hostWrData = '0;
		scanStart = 1'b0;
		startAddr = '0;
		scanLength = '0;
		repeat (5) @(posedge wclk);
		@(negedge wclk);
		reset = 1'b0;
		if (busy !== 1'b0 || done !== 1'b0 || firstErrValid !== 1'b0) begin
			$display("error at time %0t: scan flags not cleared by reset", $time);
			stimErrors = stimErrors + 1;
		end
		if (errCount !== '0)
			stimErrors += noteWrongValue("errCount", 0, 32'(errCount));
		if (checksum !== '0)
			stimErrors += noteWrongValue("checksum", 0, 32'(checksum));
		if (hostRdParityErr !== 1'b0)
			stimErrors += noteWrongValue("hostRdParityErr", 0, 32'(hostRdParityErr));
		closeTest("reset values");

		for (int n = 0; n < 200; n++) begin
			a = $urandom % memDepth;
			addrList.push_back(a);
			writeByte(a, byte_t'($urandom), 1'b0);
		end
		hostIdle();
		foreach (addrList[k]) readAndExpect(addrList[k]); // repeated addresses read the last write
		hostIdle();
		closeTest("write and readback");

		start = $urandom % memDepth; // may run past the top and wrap
		for (int k = 0; k < 300; k++) writeByte((start + k) % memDepth, byte_t'($urandom), 1'b0);
		hostIdle();
		runScan(start, 300, 1'b0);
		closeTest("clean scan");

		start = $urandom % memDepth;
		for (int k = 0; k < 256; k++) writeByte((start + k) % memDepth, byte_t'($urandom), 1'b0);
		addrList.delete();
		for (int n = 0; n < 10; n++) begin
			a = (start + $urandom % 256) % memDepth;
			addrList.push_back(a);
			writeByte(a, byte_t'($urandom), 1'b1);
		end
		hostIdle();
		runScan(start, 256, 1'b0);
		foreach (addrList[k]) readAndExpect(addrList[k]);
		hostIdle();
		closeTest("injected errors");

		// every word gets written so the full pass sees only known data
		for (int k = 0; k < memDepth; k++) writeByte(k, byte_t'($urandom), ($urandom % 64) == 0);
		writeByte(memDepth - 3, byte_t'($urandom), 1'b1); // bad words on both sides of the wrap
		writeByte(2, byte_t'($urandom), 1'b1);
		hostIdle();
		runScan(memDepth - 6, 12, 1'b0);
		runScan($urandom % memDepth, 0, 1'b0);
		runScan($urandom % memDepth, memDepth, 1'b0);
		closeTest("wrap and edge lengths");

		runScan($urandom % memDepth, 40, 1'b1);
		closeTest("timing and busy");

		$display("summary: %0d tests, %0d failed, %0d errors", testNum, testsFailed,
			stimErrors + compareErrors);
		if (stimErrors + compareErrors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- sim/memScrub_sva.sv
module memScrubChecks import scanPkg::*; (
	input logic wclk,
	input logic reset,
	input scanState_t state, // sequencer state, seen through the bind
	input logic scanRead,
	input logic busy,
	input logic done
);

	// done is a strobe, the sequencer leaves sFinish after one cycle
	doneOneCycle: assert property (@(posedge wclk) disable iff (reset) done |=> !done)
		else $error("done stayed high for a second cycle");

	// reads come only from a run that was entered straight out of sIdle
	readRunFromIdle: assert property (@(posedge wclk) disable iff (reset)
		scanRead |-> $past(scanRead) || $past(state) == sIdle)
		else $error("scanRead asserted in a run not entered from the idle state");

	// reset clears busy in the edge that samples it
	busyLowAfterReset: assert property (@(posedge wclk) reset |=> !busy)
		else $error("busy high in the cycle after reset");

	// the checker needs both drain cycles before the results are final
	doneFromDrain: assert property (@(posedge wclk) disable iff (reset)
		$rose(done) |-> $past(state) == sDrain)
		else $error("done rose without passing through the drain state");

endmodule

//--- logic/memScrubTop.sv
module memScrubTop import memTypesPkg::*, scanPkg::*; (
	input logic wclk,
	input logic reset,
	input logic hostEn,
	input logic hostWe,
	input logic hostCorrupt,
	input addr_t hostAddr,
	input byte_t hostWrData,
	output byte_t hostRdData,
	output logic hostRdParityErr,
	input logic scanStart,
	input addr_t startAddr,
	input scanLen_t scanLength,
	output logic busy,
	output logic done,
	output errCount_t errCount,
	output addr_t firstErrAddr,
	output logic firstErrValid,
	output csum_t checksum
);

	logic ramCe; // host side of the RAM
	logic ramWe;
	addr_t ramAddr;
	word9_t ramWrWord;
	word9_t ramRdWord;
	word9_t scanWord; // read-only port output for the checker
	logic loadCounter;
	logic clearResults;
	logic scanRead;
	logic scanLast;
	addr_t scanAddr;
	logic lengthZero;

	assign lengthZero = (scanLength == '0); // zero-length scans go straight to drain

	hostPort hostPort_i (
		.wclk(wclk), .reset(reset),
		.hostEn(hostEn), .hostWe(hostWe), .hostCorrupt(hostCorrupt),
		.hostAddr(hostAddr), .hostWrData(hostWrData),
		.hostRdData(hostRdData), .hostRdParityErr(hostRdParityErr),
		.ramCe(ramCe), .ramWe(ramWe), .ramAddr(ramAddr),
		.ramWrWord(ramWrWord), .ramRdWord(ramRdWord)
	);

	// host owns the read/write port, the scan only ever uses the read port
	syncRam4kx9_1rw1r ram_i (
		.wclk(wclk),
		.wce(ramCe), .we(ramWe), .wadr(ramAddr), .i(ramWrWord), .wo(ramRdWord),
		.rce(scanRead), .radr(scanAddr), .o(scanWord)
	);

	scanSequencer scanSequencer_i (
		.wclk(wclk), .reset(reset),
		.scanStart(scanStart), .lengthZero(lengthZero), .scanLast(scanLast),
		.loadCounter(loadCounter), .clearResults(clearResults), .scanRead(scanRead),
		.busy(busy), .done(done)
	);

	scanAddressCounter scanAddressCounter_i (
		.wclk(wclk), .reset(reset),
		.loadCounter(loadCounter), .startAddr(startAddr), .scanLength(scanLength),
		.step(scanRead), .scanAddr(scanAddr), .scanLast(scanLast)
	);

	scanChecker scanChecker_i (
		.wclk(wclk), .reset(reset),
		.clearResults(clearResults), .scanRead(scanRead), .scanAddr(scanAddr),
		.ramRdWord(scanWord),
		.errCount(errCount), .firstErrAddr(firstErrAddr),
		.firstErrValid(firstErrValid), .checksum(checksum)
	);

endmodule

//--- logic/scanChecker.sv
`include "scrub_params.svh"

module scanChecker import memTypesPkg::*, scanPkg::*; (
	input logic wclk,
	input logic reset,
	input logic clearResults, // zero everything for a new scan
	input logic scanRead, // a read was issued to the RAM this cycle
	input addr_t scanAddr, // address of that read
	input word9_t ramRdWord, // RAM output, one cycle behind scanRead
	output errCount_t errCount,
	output addr_t firstErrAddr, // only meaningful with firstErrValid
	output logic firstErrValid,
	output csum_t checksum
);

	logic readD; // scanRead lined up with the RAM output
	addr_t addrD; // address that belongs to ramRdWord
	logic wordBad; // parity of the returned word is even
	byte_t dataByte; // payload part of the returned word

	assign wordBad = ~^ramRdWord;
	assign dataByte = ramRdWord[`DATA_WIDTH-1:0];

	always_ff @(posedge wclk) begin
		if (reset) begin
			readD <= 1'b0;
		end else begin
			readD <= scanRead && !clearResults; // a clear never lines up with a read
		end
	end

	always_ff @(posedge wclk) begin
		addrD <= scanAddr; // payload delay, used only under readD
	end

	always_ff @(posedge wclk) begin
		if (reset) begin
			errCount <= '0;
			firstErrValid <= 1'b0;
			checksum <= '0;
		end else if (clearResults) begin
			errCount <= '0;
			firstErrValid <= 1'b0;
			checksum <= '0;
		end else if (readD) begin
			checksum <= checksum + csum_t'(dataByte); // bad words still count in the sum
			if (wordBad) begin
				errCount <= errCount + errCount_t'(1);
				firstErrValid <= 1'b1; // stays up for the rest of the scan
			end
		end
	end

	// first bad address in scan order, so a wrapped range keeps the one found before the wrap
	always_ff @(posedge wclk) begin
		if (clearResults) begin
			firstErrAddr <= '0;
		end else if (readD && wordBad && !firstErrValid) begin
			firstErrAddr <= addrD;
		end
	end

endmodule

//--- logic/scanSequencer.sv
module scanSequencer import scanPkg::*; (
	input logic wclk,
	input logic reset,
	input logic scanStart, // sampled only while idle
	input logic lengthZero, // the requested scan has no words
	input logic scanLast, // counter is on the final address
	output logic loadCounter,
	output logic clearResults,
	output logic scanRead, // RAM read enable and counter step
	output logic busy,
	output logic done
);

	scanState_t state;
	scanState_t stateNext;
	logic drainWait; // first of the two drain cycles
	logic startAccept; // a start strobe seen in sIdle

	assign startAccept = (state == sIdle) && scanStart;

	// drain takes two cycles, one for the RAM read of the last address and one for the checker
	always_comb begin
		stateNext = state;
		case (state)
			sIdle: begin
				if (scanStart) begin
					stateNext = lengthZero ? sDrain : sRun; // empty range skips the reads
				end
			end
			sRun: begin
				if (scanLast) begin
					stateNext = sDrain;
				end
			end
			sDrain: begin
				if (!drainWait) begin
					stateNext = sFinish;
				end
			end
			sFinish: stateNext = sIdle;
			default: stateNext = sIdle;
		endcase
	end

	always_ff @(posedge wclk) begin
		if (reset) begin
			state <= sIdle;
			drainWait <= 1'b0;
			busy <= 1'b0;
		end else begin
			state <= stateNext;
			drainWait <= (stateNext == sDrain) && (state != sDrain); // set on entry only
			// up one edge after the start and down in the edge that raises done
			busy <= ((state == sRun) || (state == sDrain)) && (stateNext != sFinish);
		end
	end

	assign loadCounter = startAccept; // counter and checker start in the edge we leave sIdle
	assign clearResults = startAccept;
	assign scanRead = (state == sRun);
	assign done = (state == sFinish); // busy drops in the same edge

endmodule

//--- logic/scanAddressCounter.sv
module scanAddressCounter import memTypesPkg::*, scanPkg::*; (
	input logic wclk,
	input logic reset,
	input logic loadCounter, // takes a new start and length
	input addr_t startAddr,
	input scanLen_t scanLength,
	input logic step, // one address consumed this cycle
	output addr_t scanAddr, // address to read in the current cycle
	output logic scanLast // current address is the final one of the range
);

	scanLen_t remaining; // words still to read, including the current one

	always_ff @(posedge wclk) begin
		if (reset) begin
			scanAddr <= '0;
			remaining <= '0;
		end else if (loadCounter) begin
			scanAddr <= startAddr;
			remaining <= scanLength; // a length of 0 never steps
		end else if (step) begin
			scanAddr <= scanAddr + addr_t'(1); // wraps from 4095 to 0 on its own
			remaining <= remaining - scanLen_t'(1);
		end
	end

	assign scanLast = (remaining == scanLen_t'(1));

endmodule

//--- logic/hostPort.sv
`include "scrub_params.svh"

module hostPort import memTypesPkg::*; (
	input logic wclk,
	input logic reset,
	input logic hostEn, // one request per cycle when high
	input logic hostWe, // high for write, low for read
	input logic hostCorrupt, // flips the parity bit of a write
	input addr_t hostAddr,
	input byte_t hostWrData,
	output byte_t hostRdData, // held until the next read completes
	output logic hostRdParityErr, // parity check of the word in hostRdData
	output logic ramCe,
	output logic ramWe,
	output addr_t ramAddr,
	output word9_t ramWrWord,
	input word9_t ramRdWord
);

	logic parityBit; // odd parity for the incoming byte
	logic rdPending; // RAM is presenting the word of a host read
	logic rdWordBad; // even number of ones in the returned word

	assign parityBit = ~^hostWrData; // makes the nine bits hold an odd count of ones
	assign rdWordBad = ~^ramRdWord; // odd parity fails when the xor of all nine is zero

	always_ff @(posedge wclk) begin
		if (reset) begin
			ramCe <= 1'b0;
			ramWe <= 1'b0;
		end else begin
			ramCe <= hostEn; // request goes to the RAM one cycle after the strobe
			ramWe <= hostEn && hostWe;
		end
	end

	always_ff @(posedge wclk) begin
		if (hostEn) begin
			ramAddr <= hostAddr;
			ramWrWord <= {parityBit ^ hostCorrupt, hostWrData}; // corrupt writes store bad parity
		end
	end

	// the RAM registers the address one edge after the request, so data is there one edge later
	always_ff @(posedge wclk) begin
		if (reset) begin
			rdPending <= 1'b0;
			hostRdParityErr <= 1'b0;
		end else begin
			rdPending <= ramCe && !ramWe; // only reads expect data back
			if (rdPending) begin
				hostRdParityErr <= rdWordBad;
			end
		end
	end

	always_ff @(posedge wclk) begin
		if (rdPending) begin
			hostRdData <= ramRdWord[`DATA_WIDTH-1:0]; // strip the parity bit
		end
	end

endmodule

//--- logic/syncRam4kx9_1rw1r.sv
`include "scrub_params.svh"

module syncRam4kx9_1rw1r import memTypesPkg::*; (
	input logic wclk,
	input logic wce, // read/write port enable
	input logic we, // write strobe, only acts with wce
	input addr_t wadr,
	input word9_t i,
	output word9_t wo,
	input logic rce, // read-only port enable
	input addr_t radr,
	output word9_t o
);

	word9_t mem [0:(1 << `ADDR_WIDTH)-1]; // the 4K x 9 array, never cleared
	addr_t rwadr; // registered address of the read/write port
	addr_t rradr; // registered address of the read-only port

	always_ff @(posedge wclk) begin
		if (wce) begin
			rwadr <= wadr; // latch the address on every enabled access
		end
		if (wce && we) begin
			mem[wadr] <= i; // write lands in the same edge as the address
		end
	end

	always_ff @(posedge wclk) begin
		if (rce) begin
			rradr <= radr; // second port only ever reads
		end
	end

	// read out of the registered address, the write port sees its own new data (write-first)
	assign wo = mem[rwadr];
	assign o = mem[rradr]; // valid the cycle after rce

endmodule

//--- logic/scanPkg.sv
`include "scrub_params.svh"

package scanPkg;

	// number of words to scan, one bit wider than an address so a full pass of 4096 fits
	typedef logic [`ADDR_WIDTH:0] scanLen_t;

	// byte sum over the scanned range, modulo 65536
	typedef logic [`CSUM_WIDTH-1:0] csum_t;

	// count of words with bad parity, can reach the full depth
	typedef logic [`ADDR_WIDTH:0] errCount_t;

	// scan sequencer states
	typedef enum logic [1:0] {
		sIdle, // waiting for scanStart
		sRun, // one RAM read per cycle
		sDrain, // the last reads travel through RAM and checker
		sFinish // done is up for this single cycle
	} scanState_t;

endpackage

//--- logic/memTypesPkg.sv
`include "scrub_params.svh"

package memTypesPkg;

	// word address into the RAM, both ports use the same width
	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	// host payload byte as seen outside the parity wrapper
	typedef logic [`DATA_WIDTH-1:0] byte_t;

	// stored word, bit 8 holds odd parity over bits 7 to 0
	typedef logic [`DATA_WIDTH:0] word9_t;

endpackage

//--- include/scrub_params.svh
`ifndef SCRUB_PARAMS_SVH
`define SCRUB_PARAMS_SVH

// sizing of the scrubbed byte store, shared by the type packages and the RTL

// word address into the 4K store, so the depth is 1 << ADDR_WIDTH
`define ADDR_WIDTH 12

// payload byte, the stored word adds one parity bit above it
`define DATA_WIDTH 8

// running byte sum kept by the scan checker, wraps modulo 2**CSUM_WIDTH
`define CSUM_WIDTH 16

`endif
